//--- common/console_pkg.sv
package console_pkg;

    // register byte offsets inside the 16-byte window
    typedef enum logic [3:0] {
        REG_TXDATA = 4'h0,
        REG_STATUS = 4'h4
    } reg_addr_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_e;

    // master to slave, write channels
    typedef struct packed {
        logic [3:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic        wvalid;
        logic        bready;
    } axil_wr_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        axil_resp_e bresp;
        logic       bvalid;
    } axil_wr_rsp_t;

    typedef struct packed {
        logic [3:0] araddr;
        logic       arvalid;
        logic       rready;
    } axil_rd_req_t;

    typedef struct packed {
        logic        arready;
        logic [31:0] rdata;
        axil_resp_e  rresp;
        logic        rvalid;
    } axil_rd_rsp_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } byte_push_t;

    typedef struct packed {
        logic [4:0] level; // enough for a 16 deep fifo
        logic       full;
        logic       empty;
        logic       busy;  // from the serializer
    } tx_status_t;

endpackage

//--- verilog/axil_console_regs.sv
`timescale 1ns/1ns

module axil_console_regs import console_pkg::*; (
    input  logic         clk,
    input  logic         RST,
    input  axil_wr_req_t wr_req,
    output axil_wr_rsp_t wr_rsp,
    input  axil_rd_req_t rd_req,
    output axil_rd_rsp_t rd_rsp,
    input  tx_status_t   status,
    output byte_push_t   push
);

    typedef enum logic {
        WR_IDLE,
        WR_RESP
    } wr_state_e;

    typedef enum logic {
        RD_IDLE,
        RD_RESP
    } rd_state_e;

    wr_state_e   wr_state;
    rd_state_e   rd_state;

    logic        wr_accept;
    logic        rd_accept;
    axil_resp_e  wr_resp_next;
    axil_resp_e  rd_resp_next;
    logic [31:0] rd_data_next;

    axil_resp_e  bresp_q;
    axil_resp_e  rresp_q;
    logic [31:0] rdata_q;

    // address and data are taken together, only with no response pending
    assign wr_accept = (wr_state == WR_IDLE) && wr_req.awvalid && wr_req.wvalid;
    assign rd_accept = (rd_state == RD_IDLE) && rd_req.arvalid;

    // write decode, bytes go to the fifo in the handshake cycle
    always_comb begin
        push.valid   = 1'b0;
        push.data    = wr_req.wdata[7:0];
        wr_resp_next = RESP_SLVERR;
        case (reg_addr_e'(wr_req.awaddr))
            REG_TXDATA: begin
                if (!status.full) begin
                    push.valid   = wr_accept;
                    wr_resp_next = RESP_OKAY;
                end
            end
            default: ; // status is read only
        endcase
    end

    always_comb begin
        rd_data_next = '0;
        rd_resp_next = RESP_SLVERR;
        case (reg_addr_e'(rd_req.araddr))
            REG_STATUS: begin
                rd_data_next = {21'd0, status.busy, status.full, status.empty,
                                3'd0, status.level};
                rd_resp_next = RESP_OKAY;
            end
            REG_TXDATA: rd_resp_next = RESP_OKAY; // write only, reads zero
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (RST) begin
            wr_state <= WR_IDLE;
        end else begin
            case (wr_state)
                WR_IDLE: if (wr_accept) wr_state <= WR_RESP;
                WR_RESP: if (wr_req.bready) wr_state <= WR_IDLE;
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (RST) begin
            rd_state <= RD_IDLE;
        end else begin
            case (rd_state)
                RD_IDLE: if (rd_accept) rd_state <= RD_RESP;
                RD_RESP: if (rd_req.rready) rd_state <= RD_IDLE;
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) bresp_q <= wr_resp_next;
        if (rd_accept) begin
            rresp_q <= rd_resp_next;
            rdata_q <= rd_data_next; // status snapshot
        end
    end

    assign wr_rsp.awready = wr_accept;
    assign wr_rsp.wready  = wr_accept;
    assign wr_rsp.bvalid  = (wr_state == WR_RESP);
    assign wr_rsp.bresp   = bresp_q;

    assign rd_rsp.arready = rd_accept;
    assign rd_rsp.rvalid  = (rd_state == RD_RESP);
    assign rd_rsp.rresp   = rresp_q;
    assign rd_rsp.rdata   = rdata_q;

    a_bvalid_hold: assert property (@(posedge clk) disable iff (RST)
        wr_rsp.bvalid && !wr_req.bready |=> wr_rsp.bvalid && $stable(wr_rsp.bresp));

    a_rvalid_hold: assert property (@(posedge clk) disable iff (RST)
        rd_rsp.rvalid && !rd_req.rready |=>
            rd_rsp.rvalid && $stable(rd_rsp.rdata) && $stable(rd_rsp.rresp));

endmodule

//--- tx_fifo/tx_fifo.sv
`timescale 1ns/1ns

module tx_fifo import console_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic       clk,
    input  logic       RST,
    input  byte_push_t push,
    input  logic       pop,
    output logic [7:0] rd_data,
    output logic [4:0] level,
    output logic       full,
    output logic       empty
);

    // depth must be a power of two, pointers wrap on their own
    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [7:0]       mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push.valid) wr_ptr <= wr_ptr + 1'b1;
            if (pop)        rd_ptr <= rd_ptr + 1'b1;
            // push and pop together leave the count alone
            count <= count + CNT_W'(push.valid) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push.valid) mem[wr_ptr] <= push.data;
    end

    assign rd_data = mem[rd_ptr]; // fall through
    assign full    = (count == CNT_W'(FIFO_DEPTH));
    assign empty   = (count == '0);
    assign level   = 5'(count);

    a_no_push_full: assert property (@(posedge clk) disable iff (RST)
        push.valid |-> !full);

    a_no_pop_empty: assert property (@(posedge clk) disable iff (RST)
        pop |-> !empty);

endmodule

//--- uart_tx/uart_tx_serializer.sv
`timescale 1ns/1ns

module uart_tx_serializer #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic       clk,
    input  logic       RST,
    input  logic [7:0] rd_data,
    input  logic       empty,
    output logic       pop,
    output logic       busy,
    output logic       tx
);

    localparam int BAUD_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    typedef enum logic {
        S_IDLE,
        S_SEND
    } state_e;

    state_e            state;
    logic [9:0]        shift_q;  // stop, data, start
    logic [3:0]        bit_cnt;
    logic [BAUD_W-1:0] baud_cnt;
    logic              bit_done;

    assign pop      = (state == S_IDLE) && !empty;
    assign busy     = (state == S_SEND);
    assign tx       = shift_q[0];
    assign bit_done = (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (RST) begin
            state    <= S_IDLE;
            shift_q  <= 10'h3ff; // line idles high
            bit_cnt  <= 4'd0;
            baud_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (pop) begin
                        shift_q  <= {1'b1, rd_data, 1'b0};
                        bit_cnt  <= 4'd0;
                        baud_cnt <= '0;
                        state    <= S_SEND;
                    end
                end
                S_SEND: begin
                    if (bit_done) begin
                        baud_cnt <= '0;
                        if (bit_cnt == 4'd9) begin
                            state <= S_IDLE; // stop bit done
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            shift_q <= {1'b1, shift_q[9:1]}; // lsb first
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // a pop starts a frame with the start bit on the next cycle
    a_pop_starts_frame: assert property (@(posedge clk) disable iff (RST)
        pop |-> (state == S_IDLE) ##1 (busy && !tx));

endmodule

//--- verilog/console_uart_top.sv
`timescale 1ns/1ns

module console_uart_top import console_pkg::*; #(
    parameter int CLKS_PER_BIT = 868,
    parameter int FIFO_DEPTH   = 16
) (
    input  logic         clk,
    input  logic         RST,
    input  axil_wr_req_t wr_req,
    output axil_wr_rsp_t wr_rsp,
    input  axil_rd_req_t rd_req,
    output axil_rd_rsp_t rd_rsp,
    output logic         tx
);

    byte_push_t push;
    tx_status_t status;
    logic [7:0] fifo_data;
    logic [4:0] level;
    logic       full;
    logic       empty;
    logic       pop;
    logic       busy;

    assign status = '{level: level, full: full, empty: empty, busy: busy};

    axil_console_regs regs_i (
        .clk    (clk),
        .RST    (RST),
        .wr_req (wr_req),
        .wr_rsp (wr_rsp),
        .rd_req (rd_req),
        .rd_rsp (rd_rsp),
        .status (status),
        .push   (push)
    );

    tx_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clk     (clk),
        .RST     (RST),
        .push    (push),
        .pop     (pop),
        .rd_data (fifo_data),
        .level   (level),
        .full    (full),
        .empty   (empty)
    );

    uart_tx_serializer #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) serializer_i (
        .clk     (clk),
        .RST     (RST),
        .rd_data (fifo_data),
        .empty   (empty),
        .pop     (pop),
        .busy    (busy),
        .tx      (tx)
    );

endmodule

//--- verif/uart_line_monitor.sv
`timescale 1ns/1ns

module uart_line_monitor #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic       clk,
    input  logic       RST,
    input  logic       tx,
    output logic       byte_valid,
    output logic [7:0] byte_data,
    output logic       frame_err
);

    initial begin
        byte_valid = 1'b0;
        byte_data  = 8'h00;
        frame_err  = 1'b0;
    end

    // every line sample of a frame is checked against the first one of its bit
    always begin : decode
        logic [9:0] frame;
        logic       steady;
        @(posedge clk);
        byte_valid <= 1'b0;
        if (!RST && tx === 1'b0) begin
            frame  = '0;
            steady = 1'b1;
            for (int b = 0; b < 10; b++) begin
                for (int c = 0; c < CLKS_PER_BIT; c++) begin
                    if (b != 0 || c != 0) begin
                        @(posedge clk);
                    end
                    if (c == 0) begin
                        frame = {tx, frame[9:1]}; // lsb arrives first
                    end else if (tx !== frame[9]) begin
                        steady = 1'b0; // bit shorter than a bit period
                    end
                end
            end
            byte_valid <= 1'b1;
            byte_data  <= frame[8:1];
            frame_err  <= (frame[0] !== 1'b0) || (frame[9] !== 1'b1) || !steady;
        end
    end

endmodule

//--- verif/console_uart_tb.sv
`timescale 1ns/1ns

module console_uart_tb import console_pkg::*; ();

    localparam int CLKS_PER_BIT = 8;
    localparam int FIFO_DEPTH   = 16;
    localparam int CLK_NS       = 40;
    localparam int N_DRAIN      = 12;
    localparam int N_BURST      = FIFO_DEPTH + 4;
    localparam int FRAME_CYCLES = 10 * CLKS_PER_BIT;
    localparam int DRAIN_LIMIT  = (N_BURST + 2) * (FRAME_CYCLES + 1);
    localparam int WATCHDOG_NS  = (N_DRAIN + N_BURST) * FRAME_CYCLES * CLK_NS * 2 + 40000;

    logic         clk;
    logic         RST;
    axil_wr_req_t wr_req;
    axil_wr_rsp_t wr_rsp;
    axil_rd_req_t rd_req;
    axil_rd_rsp_t rd_rsp;
    logic         tx;
    logic         mon_valid;
    logic [7:0]   mon_data;
    logic         mon_err;

    logic [7:0]   expected_q[$]; // bytes whose write got OKAY
    int           err_value;
    int           err_frame;
    int           err_other;

    console_uart_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) console_uart_top_i (
        .clk    (clk),
        .RST    (RST),
        .wr_req (wr_req),
        .wr_rsp (wr_rsp),
        .rd_req (rd_req),
        .rd_rsp (rd_rsp),
        .tx     (tx)
    );

    uart_line_monitor #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) line_monitor_i (
        .clk        (clk),
        .RST        (RST),
        .tx         (tx),
        .byte_valid (mon_valid),
        .byte_data  (mon_data),
        .frame_err  (mon_err)
    );

    always #(CLK_NS / 2) clk = ~clk;

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        err_value++;
        $display("CHECK FAILED %s: got 0x%h, expected 0x%h at %0t ns", name, got, exp, $time);
    endtask

    task automatic report_problem(input string what);
        err_other++;
        $display("ERROR: %s at %0t ns", what, $time);
    endtask

    // called right after a rising edge, returns right after one
    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                              input bit quick, output axil_resp_e resp);
        int gap;
        int stall;
        bit aw_first;
        gap      = quick ? 0 : $urandom_range(0, 3);
        stall    = quick ? 0 : $urandom_range(0, 4);
        aw_first = ($urandom_range(0, 1) == 1);
        wr_req.awaddr <= addr;
        wr_req.wdata  <= data;
        if (gap == 0 || aw_first) wr_req.awvalid <= 1'b1;
        if (gap == 0 || !aw_first) wr_req.wvalid <= 1'b1;
        if (gap != 0) begin
            repeat (gap) @(posedge clk);
            wr_req.awvalid <= 1'b1;
            wr_req.wvalid  <= 1'b1;
        end
        do @(posedge clk); while (!wr_rsp.awready);
        if (wr_rsp.wready !== 1'b1) report_mismatch("wready", 32'(wr_rsp.wready), 32'd1);
        wr_req.awvalid <= 1'b0;
        wr_req.wvalid  <= 1'b0;
        @(posedge clk);
        if (wr_rsp.bvalid !== 1'b1) report_problem("bvalid did not rise after the write handshake");
        resp = wr_rsp.bresp;
        repeat (stall) begin
            wr_req.awaddr  <= REG_STATUS; // probe that must not be taken
            wr_req.awvalid <= 1'b1;
            wr_req.wvalid  <= 1'b1;
            @(posedge clk);
            if (wr_rsp.bvalid !== 1'b1) report_mismatch("bvalid", 32'(wr_rsp.bvalid), 32'd1);
            if (wr_rsp.bresp !== resp) report_mismatch("bresp", 32'(wr_rsp.bresp), 32'(resp));
            if (wr_rsp.awready) report_problem("write accepted while a response was pending");
        end
        wr_req.awvalid <= 1'b0;
        wr_req.wvalid  <= 1'b0;
        wr_req.bready  <= 1'b1;
        @(posedge clk);
        wr_req.bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                             output axil_resp_e resp);
        int stall;
        stall = $urandom_range(0, 4);
        rd_req.araddr  <= addr;
        rd_req.arvalid <= 1'b1;
        do @(posedge clk); while (!rd_rsp.arready);
        rd_req.arvalid <= 1'b0;
        @(posedge clk);
        if (rd_rsp.rvalid !== 1'b1) report_problem("rvalid did not rise after the read handshake");
        data = rd_rsp.rdata;
        resp = rd_rsp.rresp;
        repeat (stall) begin
            rd_req.araddr  <= REG_STATUS;
            rd_req.arvalid <= 1'b1;
            @(posedge clk);
            if (rd_rsp.rvalid !== 1'b1) report_mismatch("rvalid", 32'(rd_rsp.rvalid), 32'd1);
            if (rd_rsp.rdata !== data) report_mismatch("rdata", rd_rsp.rdata, data);
            if (rd_rsp.rresp !== resp) report_mismatch("rresp", 32'(rd_rsp.rresp), 32'(resp));
            if (rd_rsp.arready) report_problem("read accepted while a response was pending");
        end
        rd_req.arvalid <= 1'b0;
        rd_req.rready  <= 1'b1;
        @(posedge clk);
        rd_req.rready <= 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] value, input bit quick, output axil_resp_e resp);
        axil_write(REG_TXDATA, {24'($urandom), value}, quick, resp); // upper bits ignored
        if (resp == RESP_OKAY) expected_q.push_back(value);
    endtask

    // each byte off the line against the oldest accepted write
    always @(posedge clk) begin
        if (mon_valid) begin
            if (mon_err) begin
                err_frame++;
                $display("ERROR: byte 0x%h framed badly on tx at %0t ns", mon_data, $time);
            end
            if (expected_q.size() == 0) begin
                report_problem($sformatf("byte 0x%h on tx with no accepted write", mon_data));
            end else begin
                if (mon_data !== expected_q[0]) report_mismatch("tx byte", 32'(mon_data),
                                                                32'(expected_q[0]));
                void'(expected_q.pop_front());
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("ERROR: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

    initial begin : main
        axil_resp_e  resp;
        logic [31:0] rdata;
        int          slverr_cnt;
        int          drain_cycles;
        void'($urandom(32'h4605fd55));
        clk       = 1'b0;
        RST       = 1'b1;
        wr_req    = '0;
        rd_req    = '0;
        err_value = 0;
        err_frame = 0;
        err_other = 0;
        repeat (2) @(posedge clk);
        RST <= 1'b0;

        repeat (20) begin
            @(posedge clk);
            if (tx !== 1'b1) report_mismatch("tx", 32'(tx), 32'd1);
        end
        axil_read(REG_STATUS, rdata, resp);
        if (rdata !== 32'h100) report_mismatch("status rdata", rdata, 32'h100);
        if (resp !== RESP_OKAY) report_mismatch("rresp", 32'(resp), 32'(RESP_OKAY));

        for (int i = 0; i < N_DRAIN; i++) begin
            send_byte(8'($urandom), 1'b0, resp);
            if (resp !== RESP_OKAY) report_mismatch("bresp", 32'(resp), 32'(RESP_OKAY));
            repeat (FRAME_CYCLES + 4 + $urandom_range(0, 20)) @(posedge clk);
        end

        slverr_cnt = 0;
        for (int i = 0; i < N_BURST; i++) begin
            send_byte(8'($urandom), 1'b1, resp);
            if (resp == RESP_SLVERR) slverr_cnt++;
            else if (resp !== RESP_OKAY) report_mismatch("bresp", 32'(resp), 32'(RESP_OKAY));
        end
        if (slverr_cnt == 0) report_problem("burst past the FIFO depth got no SLVERR");

        // error cases while the burst still drains
        axil_write(REG_STATUS, $urandom, 1'b0, resp);
        if (resp !== RESP_SLVERR) report_mismatch("bresp", 32'(resp), 32'(RESP_SLVERR));
        axil_read(4'h8, rdata, resp);
        if (rdata !== 32'h0) report_mismatch("unmapped rdata", rdata, 32'h0);
        if (resp !== RESP_SLVERR) report_mismatch("rresp", 32'(resp), 32'(RESP_SLVERR));

        // wait for the last accepted byte to come off the line
        drain_cycles = 0;
        while (expected_q.size() != 0 && drain_cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            drain_cycles++;
        end
        @(posedge clk);
        axil_read(REG_STATUS, rdata, resp);
        if (rdata !== 32'h100) report_mismatch("status rdata", rdata, 32'h100);
        if (resp !== RESP_OKAY) report_mismatch("rresp", 32'(resp), 32'(RESP_OKAY));
        if (expected_q.size() != 0) begin
            report_problem($sformatf("%0d accepted bytes never seen on tx", expected_q.size()));
        end

        $display("errors: %0d value, %0d framing, %0d other", err_value, err_frame, err_other);
        if (err_value + err_frame + err_other == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- sim.f
common/console_pkg.sv
verilog/axil_console_regs.sv
tx_fifo/tx_fifo.sv
uart_tx/uart_tx_serializer.sv
verilog/console_uart_top.sv
verif/uart_line_monitor.sv
verif/console_uart_tb.sv

//--- Makefile
VERILATOR  = verilator
TOP        = console_uart_tb
FILELIST   = sim.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_TEXT  = Testbench passed
VFLAGS     = --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
LINT_FLAGS = --lint-only -Wall --timing --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
